/* include/fpDivide_macros.svh */
`ifndef FPDIVIDE_MACROS_SVH
`define FPDIVIDE_MACROS_SVH

// binary32 field widths
`define FRAC_BITS 23
`define EXP_BITS 8
`define EXP_BIAS 127

// Fixed-point mantissa, two integer bits and thirty fraction bits
`define MANT_BITS 32

// Top fraction bits of b that select the seed
`define SEED_INDEX_BITS 4

`define MUL_STAGES 3
`define REFINE_PASSES 3

// Accepting edge to done: load, passes of issue/wait/capture, finish
`define DIV_LATENCY 22

`endif

/* logic/divStepIf.sv */
// Step commands, each a single-cycle pulse taken at the next edge
interface divStepIf;

  logic loadOperands;
  logic issueSeed;
  logic issuePass;
  logic capturePass;
  logic finish;

  modport ctrl (
    output loadOperands,
    output issueSeed,
    output issuePass,
    output capturePass,
    output finish
  );

  modport data (
    input loadOperands,
    input issueSeed,
    input issuePass,
    input capturePass,
    input finish
  );

endinterface

/* logic/divideControl.sv */
`include "fpDivide_macros.svh"

module divideControl (
  input  logic  clk,
  input  logic  resetn,
  input  logic  valid,
  output logic  ready,
  input  logic  productReady,
  input  logic  finalPass,
  output logic  clear,
  output logic  issue,
  divStepIf.ctrl step,
  output logic  done
);
  import fpDividePkg::*;

  divStateT state;
  divStateT nextState;
  logic     seedPass;   // First pass multiplies by the table seed

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      state <= Idle;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      Idle:    if (valid) nextState = Load;
      Load:    nextState = Issue;
      Issue:   nextState = Wait;
      Wait:    if (productReady) nextState = Capture;
      Capture: nextState = finalPass ? Finish : Issue;
      Finish:  nextState = Idle;
      default: nextState = Idle;
    endcase
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      seedPass <= 1'b0;
    end else if (state == Load) begin
      seedPass <= 1'b1;
    end else if (state == Capture) begin
      seedPass <= 1'b0;
    end
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      done <= 1'b0;
    end else begin
      done <= (state == Finish);
    end
  end

  assign ready = (state == Idle);
  assign clear = (state == Load);
  assign issue = (state == Issue);

  // Operands are only guaranteed on the accepting edge
  assign step.loadOperands = (state == Idle) && valid;
  assign step.issueSeed    = (state == Issue) && seedPass;
  assign step.issuePass    = (state == Issue);
  assign step.capturePass  = (state == Capture);
  assign step.finish       = (state == Finish);

endmodule

/* logic/fpDivide.sv */
`include "fpDivide_macros.svh"

module fpDivide (
  input  logic                 clk,
  input  logic                 resetn,
  input  logic                 valid,
  output logic                 ready,
  input  fpDividePkg::float32T a,
  input  fpDividePkg::float32T b,
  output logic                 done,
  output fpDividePkg::float32T z
);
  import fpDividePkg::*;

  divStepIf step ();

  logic                        clear;
  logic                        issue;
  logic                        productReady;
  logic                        finalPass;
  mantT                        numA;
  mantT                        numB;
  mantT                        denA;
  mantT                        denB;
  mantT                        numProduct;
  mantT                        denProduct;
  mantT                        quotient;
  logic                        sign;
  logic signed [`EXP_BITS+1:0] expDiff;

  divideControl divideControl_inst (
    .clk(clk), .resetn(resetn), .valid(valid), .ready(ready),
    .productReady(productReady), .finalPass(finalPass),
    .clear(clear), .issue(issue), .step(step.ctrl), .done(done)
  );

  passTimer passTimer_inst (
    .clk(clk), .resetn(resetn), .clear(clear), .issue(issue),
    .productReady(productReady), .finalPass(finalPass)
  );

  refineDatapath refineDatapath_inst (
    .clk(clk), .resetn(resetn), .a(a), .b(b), .step(step.data),
    .numA(numA), .numB(numB), .denA(denA), .denB(denB),
    .numProduct(numProduct), .denProduct(denProduct),
    .quotient(quotient), .sign(sign), .expDiff(expDiff)
  );

  // Numerator path converges to the quotient, denominator path to one
  mantissaMultiplier numMultiplier_inst (
    .clk(clk), .resetn(resetn), .opA(numA), .opB(numB), .product(numProduct)
  );

  mantissaMultiplier denMultiplier_inst (
    .clk(clk), .resetn(resetn), .opA(denA), .opB(denB), .product(denProduct)
  );

  resultPacker resultPacker_inst (
    .clk(clk), .resetn(resetn), .finish(step.finish), .quotient(quotient),
    .sign(sign), .expDiff(expDiff), .z(z)
  );

endmodule

/* logic/fpDividePkg.sv */
`include "fpDivide_macros.svh"

package fpDividePkg;

  typedef struct packed {
    logic                  sign;
    logic [`EXP_BITS-1:0]  exponent;
    logic [`FRAC_BITS-1:0] fraction;
  } float32T;

  // Value is the raw word divided by 2**30
  typedef logic [`MANT_BITS-1:0] mantT;

  typedef enum logic [2:0] {
    Idle,
    Load,
    Issue,
    Wait,     // Multiplier latency
    Capture,
    Finish
  } divStateT;

endpackage

/* logic/mantissaMultiplier.sv */
`include "fpDivide_macros.svh"

module mantissaMultiplier (
  input  logic               clk,
  input  logic               resetn,
  input  fpDividePkg::mantT  opA,
  input  fpDividePkg::mantT  opB,
  output fpDividePkg::mantT  product
);
  import fpDividePkg::*;

  logic [2*`MANT_BITS-1:0] fullProduct;
  logic [`MANT_BITS-1:0]   aligned;
  mantT                    stage [`MUL_STAGES];

  assign fullProduct = opA * opB;

  // 2.30 x 2.30 gives 4.60, keep the 2.30 window and drop the low bits
  assign aligned = fullProduct[2*`MANT_BITS-3 -: `MANT_BITS];

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      for (int i = 0; i < `MUL_STAGES; i++) begin
        stage[i] <= '0;
      end
    end else begin
      stage[0] <= aligned;
      for (int i = 1; i < `MUL_STAGES; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  assign product = stage[`MUL_STAGES-1];

endmodule

/* logic/passTimer.sv */
`include "fpDivide_macros.svh"

module passTimer (
  input  logic clk,
  input  logic resetn,
  input  logic clear,
  input  logic issue,
  output logic productReady,
  output logic finalPass
);

  localparam int WaitBits = $clog2(`MUL_STAGES + 1);
  localparam int PassBits = $clog2(`REFINE_PASSES + 2);
  localparam int TotalPasses = `REFINE_PASSES + 1;

  logic [WaitBits-1:0] waitCount;   // Zero when idle
  logic [PassBits-1:0] passCount;

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      waitCount <= '0;
    end else if (issue) begin
      waitCount <= WaitBits'(1);
    end else if (waitCount == WaitBits'(`MUL_STAGES)) begin
      waitCount <= '0;
    end else if (waitCount != '0) begin
      waitCount <= waitCount + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      passCount <= '0;
    end else if (clear) begin
      passCount <= '0;
    end else if (issue) begin
      passCount <= passCount + 1'b1;
    end
  end

  assign productReady = (waitCount == WaitBits'(`MUL_STAGES));
  assign finalPass    = (passCount == PassBits'(TotalPasses));

endmodule

/* logic/refineDatapath.sv */
`include "fpDivide_macros.svh"

module refineDatapath (
  input  logic                           clk,
  input  logic                           resetn,
  input  fpDividePkg::float32T           a,
  input  fpDividePkg::float32T           b,
  divStepIf.data                         step,
  output fpDividePkg::mantT              numA,
  output fpDividePkg::mantT              numB,
  output fpDividePkg::mantT              denA,
  output fpDividePkg::mantT              denB,
  input  fpDividePkg::mantT              numProduct,
  input  fpDividePkg::mantT              denProduct,
  output fpDividePkg::mantT              quotient,
  output logic                           sign,
  output logic signed [`EXP_BITS+1:0]    expDiff
);
  import fpDividePkg::*;

  localparam mantT Two = mantT'(1) << (`MANT_BITS - 1);
  localparam logic signed [`EXP_BITS+1:0] ExpBias = `EXP_BIAS;

  mantT                        numReg;
  mantT                        denReg;
  mantT                        seed;
  mantT                        complement;
  mantT                        factor;
  logic [`SEED_INDEX_BITS-1:0] seedIndex;

  // Hidden bit in front of the fraction, 1.f in 2.30 format
  function automatic mantT unpackMant(input logic [`FRAC_BITS-1:0] frac);
    return {2'b01, frac, {(`MANT_BITS - 2 - `FRAC_BITS){1'b0}}};
  endfunction

  always_ff @(posedge clk) begin
    if (step.loadOperands) begin
      numReg  <= unpackMant(a.fraction);
      denReg  <= unpackMant(b.fraction);
      sign    <= a.sign ^ b.sign;
      expDiff <= signed'({2'b00, a.exponent}) - signed'({2'b00, b.exponent}) + ExpBias;
    end else if (step.capturePass) begin
      numReg <= numProduct;
      denReg <= denProduct;
    end
  end

  // denReg still holds the b mantissa when the seed is used
  assign seedIndex = denReg[`MANT_BITS-3 -: `SEED_INDEX_BITS];

  // Reciprocal of each interval midpoint, 32 / (33 + 2i)
  always_comb begin
    case (seedIndex)
      4'd0:    seed = mantT'(1041204193);
      4'd1:    seed = mantT'(981706811);
      4'd2:    seed = mantT'(928641578);
      4'd3:    seed = mantT'(881018933);
      4'd4:    seed = mantT'(838042399);
      4'd5:    seed = mantT'(799063683);
      4'd6:    seed = mantT'(763549742);
      4'd7:    seed = mantT'(731058263);
      4'd8:    seed = mantT'(701219150);
      4'd9:    seed = mantT'(673720360);
      4'd10:   seed = mantT'(648296950);
      4'd11:   seed = mantT'(624722516);
      4'd12:   seed = mantT'(602802428);
      4'd13:   seed = mantT'(582368447);
      4'd14:   seed = mantT'(563274399);
      default: seed = mantT'(545392673);
    endcase
  end

  assign complement = Two - denReg;   // 2 - d
  assign factor     = step.issueSeed ? seed : complement;

  // Both products of a pass share one factor
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      numA <= '0;
      numB <= '0;
      denA <= '0;
      denB <= '0;
    end else if (step.issuePass) begin
      numA <= numReg;
      numB <= factor;
      denA <= denReg;
      denB <= factor;
    end
  end

  assign quotient = numReg;

endmodule

/* logic/resultPacker.sv */
`include "fpDivide_macros.svh"

module resultPacker (
  input  logic                        clk,
  input  logic                        resetn,
  input  logic                        finish,
  input  fpDividePkg::mantT           quotient,
  input  logic                        sign,
  input  logic signed [`EXP_BITS+1:0] expDiff,
  output fpDividePkg::float32T        z
);
  import fpDividePkg::*;

  logic                        aboveOne;
  logic [`FRAC_BITS-1:0]       fraction;
  logic signed [`EXP_BITS+1:0] expAdjusted;

  assign aboveOne = quotient[`MANT_BITS-2];   // Integer bit of 2.30

  // Quotient lies in (0.5, 2), so at most one left shift
  always_comb begin
    if (aboveOne) begin
      fraction    = quotient[`MANT_BITS-3 -: `FRAC_BITS];
      expAdjusted = expDiff;
    end else begin
      fraction    = quotient[`MANT_BITS-4 -: `FRAC_BITS];
      expAdjusted = expDiff - {{(`EXP_BITS+1){1'b0}}, 1'b1};
    end
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      z <= '0;
    end else if (finish) begin
      z.sign     <= sign;
      z.exponent <= expAdjusted[`EXP_BITS-1:0];
      z.fraction <= fraction;   // Truncated
    end
  end

endmodule

/* run.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f src.f --top-module fpDivideTb -o fpDivideSim; then
  echo "Verilator build failed"
  exit 1
fi

simOutput="$(./obj_dir/fpDivideSim)"
simStatus=$?
echo "$simOutput"

if [ "$simStatus" -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -q -F "=== PASS ===" <<< "$simOutput"; then
  echo "Simulation passed"
  exit 0
fi

echo "Simulation failed"
exit 1

/* sim/fpDivideTb.sv */
`include "fpDivide_macros.svh"

module fpDivideTb;
  timeunit 1ns;
  timeprecision 1ps;
  import fpDividePkg::*;

  localparam int WaitLimit = 4 * `DIV_LATENCY;
  localparam int RandomCases = 200;
  localparam real MaxRelErr = 1.0 / 1048576.0;   // 2**-20
  localparam float32T DecoyA = 32'h42F60000;       // 123.0, must never be used
  localparam float32T DecoyB = 32'h3F400000;

  // Each entry is {a, b}
  localparam int NumCases = 28;
  localparam logic [63:0] Cases [NumCases] = '{
    {32'h40E00000, 32'h40000000},   // Sign combinations of 7 / 2
    {32'hC0E00000, 32'h40000000},
    {32'h40E00000, 32'hC0000000},
    {32'hC0E00000, 32'hC0000000},
    {32'h40490FDB, 32'h40490FDB},   // Equal operands
    {32'h3DCCCCCD, 32'h3DCCCCCD},
    {32'hC2C80000, 32'hC2C80000},
    {32'h402DF854, 32'h3F800000},   // Divide by one and two
    {32'hC1200000, 32'h3F800000},
    {32'h3DCCCCCD, 32'h40000000},
    {32'h40490FDB, 32'h3F800000},   // b at each seed interval start
    {32'h40490FDB, 32'h3F880000},
    {32'h40490FDB, 32'h3F900000},
    {32'h40490FDB, 32'h3F980000},
    {32'h40490FDB, 32'h3FA00000},
    {32'h40490FDB, 32'h3FA80000},
    {32'h40490FDB, 32'h3FB00000},
    {32'h40490FDB, 32'h3FB80000},
    {32'h40490FDB, 32'h3FC00000},
    {32'h40490FDB, 32'h3FC80000},
    {32'h40490FDB, 32'h3FD00000},
    {32'h40490FDB, 32'h3FD80000},
    {32'h40490FDB, 32'h3FE00000},
    {32'h40490FDB, 32'h3FE80000},
    {32'h40490FDB, 32'h3FF00000},
    {32'h40490FDB, 32'h3FF80000},
    {32'h3F800001, 32'h3FFFFFFF},   // Quotient just above one half
    {32'h3FFFFFFF, 32'h3F800001}    // Quotient just below two
  };

  logic    clk;
  logic    resetn;
  logic    valid;
  logic    ready;
  float32T a;
  float32T b;
  logic    done;
  float32T z;
  float32T lastZ;   // Result of the previous division

  fpDivide fpDivide_inst (
    .clk(clk), .resetn(resetn), .valid(valid), .ready(ready),
    .a(a), .b(b), .done(done), .z(z)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stopRun();
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // Normal binary32 widened to binary64
  function automatic real toReal(input float32T f);
    logic [63:0] bits;
    bits = {f.sign, {3'b000, f.exponent} + 11'd896, f.fraction, 29'd0};
    return $bitstoreal(bits);
  endfunction

  function automatic float32T randomOperand();
    float32T f;
    f.sign     = 1'($urandom);
    f.exponent = 8'($urandom_range(154, 100));
    f.fraction = 23'($urandom);
    return f;
  endfunction

  task automatic checkBit(input string name, input logic got, input logic expected);
    if (got !== expected) begin
      $display("FAIL t=%0t %s got %b expected %b", $time, name, got, expected);
      stopRun();
    end
  endtask

  task automatic checkHeld(input string name, input float32T got, input float32T expected);
    if (got !== expected) begin
      $display("FAIL t=%0t %s got %h expected %h", $time, name, got, expected);
      stopRun();
    end
  endtask

  task automatic checkFloat(input float32T got, input float32T opA, input float32T opB);
    real  expected;
    real  actual;
    real  relErr;
    logic expSign;
    expSign = opA.sign ^ opB.sign;
    if (got.sign !== expSign) begin
      $display("FAIL t=%0t z.sign got %b expected %b", $time, got.sign, expSign);
      stopRun();
    end
    expected = toReal(opA) / toReal(opB);
    actual   = toReal(got);
    relErr   = (actual - expected) / expected;
    if (relErr < 0.0) relErr = -relErr;
    if (relErr > MaxRelErr) begin
      $display("FAIL t=%0t z got %h (%g) expected %g for %h / %h",
               $time, got, actual, expected, opA, opB);
      stopRun();
    end
  endtask

  // Starts and ends at a falling edge
  task automatic runDivision(input float32T opA, input float32T opB, input logic injectBusy);
    int      cycles;
    int      edges;
    logic    finished;
    float32T result;
    cycles = 0;
    while (!ready) begin
      if (cycles >= WaitLimit) begin
        $display("Timeout: ready did not rise within %0d cycles", WaitLimit);
        stopRun();
      end
      @(negedge clk);
      cycles++;
    end
    @(posedge clk);
    valid <= 1'b1;
    a     <= opA;
    b     <= opB;
    @(posedge clk);   // Accepting edge
    valid <= 1'b0;
    edges    = 0;
    finished = 1'b0;
    while (!finished) begin
      @(negedge clk);
      checkBit("done", done, edges == `DIV_LATENCY);
      if (done) begin
        finished = 1'b1;
      end else begin
        checkBit("ready", ready, 1'b0);
        checkHeld("z", z, lastZ);
        if (edges >= WaitLimit) begin
          $display("Timeout: done did not rise within %0d cycles", WaitLimit);
          stopRun();
        end
        @(posedge clk);
        edges++;
        if (injectBusy) begin
          valid <= (edges == 3) || (edges == 4);   // Offered while busy
          if (edges == 3) begin
            a <= DecoyA;
            b <= DecoyB;
          end
        end
      end
    end
    checkFloat(z, opA, opB);
    result = z;
    @(posedge clk);
    @(negedge clk);
    checkBit("done", done, 1'b0);   // Single cycle pulse
    checkHeld("z", z, result);
    lastZ = result;
  endtask

  initial begin
    float32T ra;
    float32T rb;
    resetn = 1'b0;
    valid  = 1'b0;
    a      = '0;
    b      = '0;
    lastZ  = '0;
    void'($urandom(51));

    repeat (5) @(posedge clk);
    resetn <= 1'b1;
    @(negedge clk);
    checkBit("ready", ready, 1'b1);
    checkBit("done", done, 1'b0);
    checkHeld("z", z, '0);

    for (int i = 0; i < NumCases; i++) begin
      runDivision(Cases[i][63:32], Cases[i][31:0], 1'b0);
    end

    // Second valid during a busy division is ignored
    runDivision(32'h40490FDB, 32'h40E00000, 1'b1);
    runDivision(32'hC1200000, 32'h40400000, 1'b0);

    for (int i = 0; i < RandomCases; i++) begin
      ra = randomOperand();
      rb = randomOperand();
      runDivision(ra, rb, 1'b0);
    end

    $display("=== PASS ===");
    $finish;
  end

endmodule

/* src.f */
+incdir+include
logic/fpDividePkg.sv
logic/divStepIf.sv
logic/mantissaMultiplier.sv
logic/divideControl.sv
logic/passTimer.sv
logic/refineDatapath.sv
logic/resultPacker.sv
logic/fpDivide.sv
sim/fpDivideTb.sv
